/* files.f */
+incdir+test
rtl/fpuPkg.sv
rtl/fpuMulSingle.sv
rtl/fpuCompareSingle.sv
rtl/fpuResultStage.sv
rtl/fpuExUnit.sv
test/tbFpuExUnit.sv

/* rtl/fpuCompareSingle.sv */
`timescale 1ns/100ps

module fpuCompareSingle import fpuPkg::*;
(
	input logic clock,
	input logic rst,
	input logic exHold,
	input fpWord_t valS,
	input fpWord_t valT,
	input logic isGreater,
	output logic cmpFlag
);

	logic sgnS;
	logic sgnT;
	logic [expMsb:0] magS;
	logic [expMsb:0] magT;
	logic bothZero;
	logic isEqual;
	logic isAbove;

	// stage 1 registers
	logic isEqual1;
	logic isAbove1;
	logic isGreater1;

	always_comb
	begin
		sgnS = valS[signBit];
		sgnT = valT[signBit];
		magS = valS[expMsb:0];
		magT = valT[expMsb:0];

		// +0 and -0 compare equal
		bothZero = (magS == '0) && (magT == '0);
		isEqual = bothZero || (valS == valT);

		if (bothZero)
		begin
			isAbove = 1'b0;
		end
		else if (sgnS != sgnT)
		begin
			// the positive one is greater
			isAbove = !sgnS;
		end
		else if (sgnS)
		begin
			// both negative, smaller magnitude wins
			isAbove = magS < magT;
		end
		else
		begin
			isAbove = magS > magT;
		end
	end

	always_ff @(posedge clock)
	begin
		if (rst)
		begin
			isEqual1 <= 1'b0;
			isAbove1 <= 1'b0;
			isGreater1 <= 1'b0;
			cmpFlag <= 1'b0;
		end
		else if (!exHold)
		begin
			isEqual1 <= isEqual;
			isAbove1 <= isAbove;
			isGreater1 <= isGreater;

			// stage 2 keeps only the relation that was asked for
			cmpFlag <= isGreater1 ? isAbove1 : isEqual1;
		end
	end

endmodule

/* rtl/fpuExUnit.sv */
`timescale 1ns/100ps

module fpuExUnit import fpuPkg::*;
(
	input logic clock,
	input logic rst,
	input logic exHold,
	input fpWord_t valS,
	input fpWord_t valT,
	input fpuOp_t exOp,
	output fpWord_t valResult,
	output logic flagT
);

	fpWord_t mulResult;
	logic cmpFlag;
	logic isGreater;

	// compare unit only needs to know which relation to keep
	assign isGreater = (exOp == opCmpGt);

	fpuMulSingle mulUnit
	(
		.clock(clock),
		.rst(rst),
		.exHold(exHold),
		.valS(valS),
		.valT(valT),
		.mulResult(mulResult)
	);

	fpuCompareSingle cmpUnit
	(
		.clock(clock),
		.rst(rst),
		.exHold(exHold),
		.valS(valS),
		.valT(valT),
		.isGreater(isGreater),
		.cmpFlag(cmpFlag)
	);

	// merges both unit outputs with the delayed sign ops
	fpuResultStage resultUnit
	(
		.clock(clock),
		.rst(rst),
		.exHold(exHold),
		.exOp(exOp),
		.valS(valS),
		.mulResult(mulResult),
		.cmpFlag(cmpFlag),
		.valResult(valResult),
		.flagT(flagT)
	);

endmodule

/* rtl/fpuMulSingle.sv */
`timescale 1ns/100ps

module fpuMulSingle import fpuPkg::*;
(
	input logic clock,
	input logic rst,
	input logic exHold,
	input fpWord_t valS,
	input fpWord_t valT,
	output fpWord_t mulResult
);

	// unpacked operand fields
	logic sgnS;
	logic sgnT;
	fpExp_t expS;
	fpExp_t expT;
	fpMant_t mantS;
	fpMant_t mantT;

	// stage 1 values, before the register
	logic sgnProd;
	fpExp_t expSum;
	fpExp_t expSumP1;
	logic [prodWidth-1:0] product;
	logic [mantWidth:0] fracTop;
	logic zeroIn;

	// stage 1 registers
	logic sgnProd1;
	fpExp_t expSum1;
	fpExp_t expSumP1_1;
	logic [mantWidth:0] fracTop1;
	logic zeroIn1;

	// stage 2 values, before the register
	fpExp_t expNorm;
	logic [expLsb-1:0] mantNorm;
	logic flushZero;
	fpWord_t resultNext;

	// field extraction, hidden bit restored
	always_comb
	begin
		sgnS = valS[signBit];
		sgnT = valT[signBit];
		expS = {1'b0, valS[expMsb:expLsb]};
		expT = {1'b0, valT[expMsb:expLsb]};
		mantS = {1'b1, valS[expLsb-1:0]};
		mantT = {1'b1, valT[expLsb-1:0]};
	end

	// sign, exponent sum and full mantissa product
	always_comb
	begin
		sgnProd = sgnS ^ sgnT;
		expSum = expS + expT - fpExp_t'(expBias);
		expSumP1 = expSum + fpExp_t'(1);
		product = prodWidth'(mantS) * prodWidth'(mantT);

		// keep bits 47 down to 23, the rest is truncated
		fracTop = product[prodWidth-1:expLsb];

		// denormals and zeros both have a zero exponent field
		zeroIn = (expS == '0) || (expT == '0);
	end

	always_ff @(posedge clock)
	begin
		if (rst)
		begin
			sgnProd1 <= 1'b0;
			expSum1 <= '0;
			expSumP1_1 <= '0;
			fracTop1 <= '0;
			zeroIn1 <= 1'b0;
		end
		else if (!exHold)
		begin
			sgnProd1 <= sgnProd;
			expSum1 <= expSum;
			expSumP1_1 <= expSumP1;
			fracTop1 <= fracTop;
			zeroIn1 <= zeroIn;
		end
	end

	// normalize by one place when the product reached [2,4)
	always_comb
	begin
		if (fracTop1[mantWidth])
		begin
			expNorm = expSumP1_1;
			mantNorm = fracTop1[mantWidth-1:1];
		end
		else
		begin
			expNorm = expSum1;
			mantNorm = fracTop1[mantWidth-2:0];
		end

		// wrapped negative exponent (top bits 11) or exactly zero means underflow
		flushZero = zeroIn1 ||
			(expNorm[expWidth-1:expWidth-2] == 2'b11) ||
			(expNorm[expWidth-2:0] == '0);

		if (flushZero)
		begin
			resultNext = '0;
		end
		else
		begin
			resultNext = {sgnProd1, expNorm[expWidth-2:0], mantNorm};
		end
	end

	always_ff @(posedge clock)
	begin
		if (rst)
		begin
			mulResult <= '0;
		end
		else if (!exHold)
		begin
			mulResult <= resultNext;
		end
	end

endmodule

/* rtl/fpuPkg.sv */
package fpuPkg;

	// word and field widths
	localparam int wordWidth = 32;
	localparam int expWidth = 9;
	localparam int mantWidth = 24;
	localparam int prodWidth = 2 * mantWidth;

	// single-precision field positions
	localparam int signBit = 31;
	localparam int expMsb = 30;
	localparam int expLsb = 23;

	// exponent bias for single precision
	localparam int expBias = 127;

	// one operand or one result word
	typedef logic [wordWidth-1:0] fpWord_t;

	// exponent with a guard bit on top, for underflow detection
	typedef logic [expWidth-1:0] fpExp_t;

	// mantissa with the hidden bit restored
	typedef logic [mantWidth-1:0] fpMant_t;

	// execute-slot operation codes
	typedef enum logic [3:0]
	{
		opMov = 4'd0,
		opMul = 4'd1,
		opCmpEq = 4'd2,
		opCmpGt = 4'd3,
		opNeg = 4'd4,
		opAbs = 4'd5
	} fpuOp_t;

endpackage

/* rtl/fpuResultStage.sv */
`timescale 1ns/100ps

module fpuResultStage import fpuPkg::*;
(
	input logic clock,
	input logic rst,
	input logic exHold,
	input fpuOp_t exOp,
	input fpWord_t valS,
	input fpWord_t mulResult,
	input logic cmpFlag,
	output fpWord_t valResult,
	output logic flagT
);

	// move, negate or absolute value, formed at issue
	fpWord_t signWord;

	// operation and sign word, delayed to line up with the units
	fpuOp_t exOp1;
	fpuOp_t exOp2;
	fpWord_t signWord1;
	fpWord_t signWord2;

	always_comb
	begin
		signWord = valS;
		case (exOp)
			opNeg:
			begin
				signWord[signBit] = !valS[signBit];
			end
			opAbs:
			begin
				signWord[signBit] = 1'b0;
			end
			default:
			begin
				signWord = valS;
			end
		endcase
	end

	always_ff @(posedge clock)
	begin
		if (rst)
		begin
			exOp1 <= opMov;
			exOp2 <= opMov;
			signWord1 <= '0;
			signWord2 <= '0;
		end
		else if (!exHold)
		begin
			exOp1 <= exOp;
			exOp2 <= exOp1;
			signWord1 <= signWord;
			signWord2 <= signWord1;
		end
	end

	// write-back select
	always_comb
	begin
		case (exOp2)
			opMul:
			begin
				valResult = mulResult;
				flagT = 1'b0;
			end
			opCmpEq, opCmpGt:
			begin
				valResult = {{(signBit){1'b0}}, cmpFlag};
				flagT = cmpFlag;
			end
			default:
			begin
				valResult = signWord2;
				flagT = 1'b0;
			end
		endcase
	end

endmodule

/* test/fpuVectors.svh */
// columns: operation, valS, valT, expected valResult, expected flagT,
// and the hold cycles inserted while that row waits to issue
task automatic loadFixedRows();
	begin
		// multiply, 1.5 x 1.5 takes the normalize path
		addRow(opMul, 32'h3FC00000, 32'h3FC00000, 32'h40100000, 1'b0, 0);
		addRow(opMul, 32'h40000000, 32'h40400000, 32'h40C00000, 1'b0, 0);
		addRow(opMul, 32'hC0000000, 32'h40400000, 32'hC0C00000, 1'b0, 0);
		addRow(opMul, 32'h3F000000, 32'hC0400000, 32'hBFC00000, 1'b0, 0);
		addRow(opMul, 32'hBFC00000, 32'hBFC00000, 32'h40100000, 1'b0, 0);
		// zero, denormal, minus zero, 2^-70 squared, exponent sum exactly zero
		addRow(opMul, 32'h00000000, 32'h40400000, 32'h00000000, 1'b0, 0);
		addRow(opMul, 32'h00400000, 32'h40000000, 32'h00000000, 1'b0, 0);
		addRow(opMul, 32'h80000000, 32'h40A00000, 32'h00000000, 1'b0, 0);
		addRow(opMul, 32'h1C800000, 32'h1C800000, 32'h00000000, 1'b0, 0);
		addRow(opMul, 32'h20000000, 32'h1F800000, 32'h00000000, 1'b0, 0);
		// compares
		addRow(opCmpEq, 32'h40000000, 32'h40000000, 32'h00000001, 1'b1, 0);
		addRow(opCmpEq, 32'h40000000, 32'h40400000, 32'h00000000, 1'b0, 0);
		addRow(opCmpEq, 32'h00000000, 32'h80000000, 32'h00000001, 1'b1, 0);
		addRow(opCmpGt, 32'h3F800000, 32'hBF800000, 32'h00000001, 1'b1, 0);
		addRow(opCmpGt, 32'hBF800000, 32'h3F800000, 32'h00000000, 1'b0, 0);
		addRow(opCmpGt, 32'hC0000000, 32'hC0400000, 32'h00000001, 1'b1, 0);
		addRow(opCmpGt, 32'hC0400000, 32'hC0000000, 32'h00000000, 1'b0, 0);
		// sign ops, a 3-cycle hold sits in the middle of the stream
		addRow(opMov, 32'h40490FDB, 32'h00000000, 32'h40490FDB, 1'b0, 0);
		addRow(opNeg, 32'h40490FDB, 32'h00000000, 32'hC0490FDB, 1'b0, 3);
		addRow(opNeg, 32'hC0000000, 32'h00000000, 32'h40000000, 1'b0, 0);
		addRow(opAbs, 32'hC0490FDB, 32'h00000000, 32'h40490FDB, 1'b0, 0);
		addRow(opAbs, 32'h3F800000, 32'h00000000, 32'h3F800000, 1'b0, 0);
	end
endtask

/* test/tbFpuExUnit.sv */
`timescale 1ns/100ps

module tbFpuExUnit import fpuPkg::*;
();

	localparam int maxRows = 48;
	localparam int edgeTimeout = 20;

	logic clock;
	logic rst;
	logic exHold;
	fpWord_t valS;
	fpWord_t valT;
	fpuOp_t exOp;
	fpWord_t valResult;
	logic flagT;

	// stimulus and expected values, one entry per row
	fpuOp_t opTab[maxRows];
	fpWord_t sTab[maxRows];
	fpWord_t tTab[maxRows];
	fpWord_t resTab[maxRows];
	logic flagTab[maxRows];
	int holdTab[maxRows];
	int numRows;

	integer seed;
	int testsRun;
	int testsFailed;
	bit timedOut;

	fpuExUnit uut
	(
		.clock(clock),
		.rst(rst),
		.exHold(exHold),
		.valS(valS),
		.valT(valT),
		.exOp(exOp),
		.valResult(valResult),
		.flagT(flagT)
	);

	initial
	begin
		clock = 1'b0;
		forever #50 clock = ~clock;
	end

	task automatic addRow(input fpuOp_t op, input fpWord_t s, input fpWord_t t,
		input fpWord_t res, input logic flag, input int hold);
		begin
			opTab[numRows] = op;
			sTab[numRows] = s;
			tTab[numRows] = t;
			resTab[numRows] = res;
			flagTab[numRows] = flag;
			holdTab[numRows] = hold;
			numRows++;
		end
	endtask

	`include "fpuVectors.svh"

	// exponent field kept in 100..150 so no product overflows
	function automatic fpWord_t randomOperand();
		logic sgn;
		logic [7:0] ex;
		logic [22:0] frac;
		begin
			sgn = 1'($random(seed));
			ex = 8'(100 + ($unsigned($random(seed)) % 51));
			frac = 23'($random(seed));
			return {sgn, ex, frac};
		end
	endfunction

	// truncating reference product with flush to zero
	function automatic fpWord_t modelMul(input fpWord_t a, input fpWord_t b);
		logic [47:0] prod;
		logic [22:0] frac;
		int e;
		begin
			if (a[30:23] == 8'd0 || b[30:23] == 8'd0)
			begin
				return '0;
			end
			prod = 48'({1'b1, a[22:0]}) * 48'({1'b1, b[22:0]});
			e = int'(a[30:23]) + int'(b[30:23]) - expBias;
			if (prod[47])
			begin
				e = e + 1;
				frac = prod[46:24];
			end
			else
			begin
				frac = prod[45:23];
			end
			if (e <= 0)
			begin
				return '0;
			end
			return {a[31] ^ b[31], e[7:0], frac};
		end
	endfunction

	task automatic addRandomRow();
		fpWord_t a;
		fpWord_t b;
		begin
			a = randomOperand();
			b = randomOperand();
			addRow(opMul, a, b, modelMul(a, b), 1'b0, 0);
		end
	endtask

	task automatic checkRow(input int idx);
		bit ok;
		begin
			ok = 1'b1;
			if (valResult !== resTab[idx])
			begin
				$display("FAIL %0t: row %0d valResult %h, expected %h",
					$time, idx, valResult, resTab[idx]);
				ok = 1'b0;
			end
			if (flagT !== flagTab[idx])
			begin
				$display("FAIL %0t: row %0d flagT %b, expected %b", $time, idx, flagT, flagTab[idx]);
				ok = 1'b0;
			end
			testsRun++;
			testsFailed += ok ? 0 : 1;
			$display("row %0d %s: %s", idx, opTab[idx].name(), ok ? "ok" : "wrong");
		end
	endtask

	// outputs must not move while the pipeline is frozen
	task automatic holdStretch(input int cycles);
		fpWord_t heldResult;
		logic heldFlag;
		bit ok;
		begin
			ok = 1'b1;
			exHold = 1'b1;
			heldResult = valResult;
			heldFlag = flagT;
			for (int k = 0; k < cycles; k++)
			begin
				@(posedge clock);
				#1;
				if (valResult !== heldResult || flagT !== heldFlag)
				begin
					$display("FAIL %0t: output moved during hold, valResult %h, expected %h",
						$time, valResult, heldResult);
					ok = 1'b0;
				end
			end
			exHold = 1'b0;
			testsRun++;
			testsFailed += ok ? 0 : 1;
			$display("hold of %0d cycles: %s", cycles, ok ? "ok" : "wrong");
		end
	endtask

	task automatic waitUnheldEdge(output bit seen);
		int cycles;
		begin
			seen = 1'b0;
			cycles = 0;
			while (!seen && cycles < edgeTimeout)
			begin
				@(posedge clock);
				seen = !exHold;
				cycles++;
			end
			#1;
		end
	endtask

	initial
	begin
		bit seen;
		seed = 32'h7f9;
		rst = 1'b1;
		// hold raised and live operands during reset, only rst can clear the pipeline
		exHold = 1'b1;
		valS = 32'h40490FDB;
		valT = 32'h3F800000;
		exOp = opNeg;
		numRows = 0;
		testsRun = 0;
		testsFailed = 0;
		timedOut = 1'b0;
		loadFixedRows();
		for (int r = 0; r < 20; r++)
		begin
			addRandomRow();
		end
		repeat (5) @(posedge clock);
		#1;
		rst = 1'b0;
		exHold = 1'b0;
		testsRun++;
		if (valResult !== '0 || flagT !== 1'b0)
		begin
			$display("FAIL %0t: after reset valResult %h flagT %b", $time, valResult, flagT);
			testsFailed++;
		end
		$display("reset state: done");
		// output after each unheld edge belongs to the row issued one edge earlier
		for (int i = 0; i <= numRows && !timedOut; i++)
		begin
			exOp = (i < numRows) ? opTab[i] : opMov;
			valS = (i < numRows) ? sTab[i] : '0;
			valT = (i < numRows) ? tTab[i] : '0;
			if (i < numRows && holdTab[i] > 0)
			begin
				holdStretch(holdTab[i]);
			end
			waitUnheldEdge(seen);
			if (!seen)
			begin
				$display("timeout: no unheld clock edge within %0d cycles", edgeTimeout);
				timedOut = 1'b1;
			end
			else if (i > 0)
			begin
				checkRow(i - 1);
			end
		end
		$display("tests run %0d, failed %0d", testsRun, testsFailed);
		if (testsFailed == 0 && !timedOut)
		begin
			$display("PASS: all tests");
		end
		else
		begin
			$display("FAIL: see errors above");
		end
		$finish;
	end

endmodule
